//--- bench/pcpu_asserts.sv
`timescale 1ns/100ps

module pcpu_asserts import cpu_pkg::*; (
	input logic clk_cpu,
	input logic rst,
	input logic retire_en,
	input logic [REG_ADDR_W-1:0] retire_reg,
	input logic store_en,
	input logic [XLEN-1:0] store_addr
);

	// violations so far, watched from the testbench top
	int fail_count = 0;

	//////////////////////////////////////////////////
	// reset
	//////////////////////////////////////////////////

	quiet_in_reset: assert property (@(posedge clk_cpu)
		rst |-> (!retire_en && !store_en))
		else begin
			$error("retire or store active while reset is high");
			fail_count++;
		end

	//////////////////////////////////////////////////
	// writeback
	//////////////////////////////////////////////////

	// r0 writes are dropped in decode
	no_r0_write: assert property (@(posedge clk_cpu) disable iff (rst)
		retire_en |-> (retire_reg != '0))
		else begin
			$error("register 0 reported as written");
			fail_count++;
		end

	// r11 only appears in squashed slots
	no_squashed_write: assert property (@(posedge clk_cpu) disable iff (rst)
		retire_en |-> (retire_reg != 5'd11))
		else begin
			$error("instruction behind a taken branch or jump retired");
			fail_count++;
		end

	//////////////////////////////////////////////////
	// stores
	//////////////////////////////////////////////////

	store_addr_ok: assert property (@(posedge clk_cpu) disable iff (rst)
		store_en |-> (store_addr[1:0] == 2'b00 && store_addr < RAM_WORDS * 4))
		else begin
			$error("store address 0x%08h unaligned or outside the data RAM", store_addr);
			fail_count++;
		end

endmodule

//--- bench/pcpu_tb.sv
`timescale 1ns/100ps

module pcpu_tb import cpu_pkg::*; ();

	localparam int NUM_STORES = 8;
	localparam int STORE_TIMEOUT = 100;
	localparam int RESET_TIMEOUT = 50;
	localparam int QUIET_CYCLES = 20;

	logic clk_cpu;
	logic rst;
	logic retire_en;
	logic [REG_ADDR_W-1:0] retire_reg;
	logic [XLEN-1:0] retire_data;
	logic store_en;
	logic [XLEN-1:0] store_addr;
	logic [XLEN-1:0] store_data;

	logic [XLEN-1:0] exp_addr [NUM_STORES];
	logic [XLEN-1:0] exp_data [NUM_STORES];
	logic [XLEN-1:0] exp_reg [NUM_REGS];
	bit reg_known [NUM_REGS];

	tb_clock u_clock (
		.clk_cpu (clk_cpu),
		.rst     (rst)
	);

	pcpu_top dut (
		.clk_cpu     (clk_cpu),
		.rst         (rst),
		.retire_en   (retire_en),
		.retire_reg  (retire_reg),
		.retire_data (retire_data),
		.store_en    (store_en),
		.store_addr  (store_addr),
		.store_data  (store_data)
	);

	bind pcpu_top pcpu_asserts u_chk (.*);

	task automatic stop_with_failure(input string msg);
		$display("%s", msg);
		$display("** FAIL **");
		$fatal(1, "stopped at the first failed check");
	endtask

	//////////////////////////////////////////////////
	// expected stores, from the program's semantics
	//////////////////////////////////////////////////

	task automatic expect_reg(input int idx, input logic [XLEN-1:0] value);
		exp_reg[idx] = value;
		reg_known[idx] = 1'b1;
	endtask

	task automatic build_expected();
		int i;
		for (i = 0; i < NUM_REGS; i++) begin
			exp_reg[i] = '0;
			reg_known[i] = 1'b0;
		end
		// final register values, r0 and r11 are never written
		expect_reg(1, 32'd5);
		expect_reg(2, 32'd7);
		expect_reg(3, 32'd12);
		expect_reg(4, 32'd2);
		expect_reg(5, 32'h1234_0000);
		// lw reads back the word stored at address 0
		expect_reg(6, 32'd12);
		expect_reg(7, 32'd24);
		expect_reg(8, 32'd1);
		expect_reg(9, 32'd7);
		expect_reg(10, 32'd5);
		expect_reg(12, 32'h0000_600d);
		exp_addr = '{32'd0, 32'd4, 32'd8, 32'd12, 32'd16, 32'd20, 32'd24, 32'd28};
		exp_data = '{32'd12, 32'd2, 32'h1234_0000, 32'd24, 32'd1, 32'd7, 32'd5,
			32'h0000_600d};
	endtask

	task automatic wait_reset_release();
		int cycles;
		cycles = 0;
		while (rst && cycles < RESET_TIMEOUT) begin
			@(negedge clk_cpu);
			cycles++;
		end
		assert (!rst) else stop_with_failure("reset was never released");
	endtask

	// outputs are sampled on the falling edge
	task automatic wait_store(output bit seen);
		int cycles;
		seen = 1'b0;
		cycles = 0;
		while (!seen && cycles < STORE_TIMEOUT) begin
			@(negedge clk_cpu);
			seen = store_en;
			cycles++;
		end
	endtask

	task automatic check_no_extra_store();
		int cycles;
		for (cycles = 0; cycles < QUIET_CYCLES; cycles++) begin
			@(negedge clk_cpu);
			assert (!store_en) else stop_with_failure($sformatf(
				"unexpected store to 0x%08h after the last expected store", store_addr));
		end
	endtask

	// a bound assertion firing ends the run
	always @(negedge clk_cpu) begin
		if (dut.u_chk.fail_count != 0) begin
			stop_with_failure("a bound assertion on pcpu_top failed");
		end
	end

	// each register write carries the value the program leaves there
	always @(negedge clk_cpu) begin
		if (!rst && retire_en) begin
			assert (reg_known[retire_reg]) else stop_with_failure($sformatf(
				"register r%0d written although the program never writes it", retire_reg));
			assert (retire_data == exp_reg[retire_reg]) else stop_with_failure($sformatf(
				"Mismatch at %0t: r%0d retired 0x%08h, expected 0x%08h",
				$time, retire_reg, retire_data, exp_reg[retire_reg]));
		end
	end

	//////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////

	initial begin
		int idx;
		bit seen;
		build_expected();
		wait_reset_release();
		for (idx = 0; idx < NUM_STORES; idx++) begin
			wait_store(seen);
			assert (seen) else stop_with_failure($sformatf(
				"timeout, store %0d did not appear within %0d cycles", idx, STORE_TIMEOUT));
			assert (store_addr == exp_addr[idx] && store_data == exp_data[idx])
				else stop_with_failure($sformatf(
					"Mismatch at %0t: store %0d got 0x%08h at 0x%08h, expected 0x%08h at 0x%08h",
					$time, idx, store_data, store_addr, exp_data[idx], exp_addr[idx]));
		end
		check_no_extra_store();
		if (dut.u_chk.fail_count == 0) begin
			$display("** PASS **");
			$finish;
		end else begin
			stop_with_failure("a bound assertion on pcpu_top failed");
		end
	end

endmodule

//--- bench/tb_clock.sv
`timescale 1ns/100ps

module tb_clock (
	output logic clk_cpu,
	output logic rst
);

	// 10 ns period
	initial begin
		clk_cpu = 1'b0;
		forever #5 clk_cpu = ~clk_cpu;
	end

	// reset held for the first 5 rising edges
	initial begin
		rst = 1'b1;
		repeat (5) @(posedge clk_cpu);
		rst <= 1'b0;
	end

endmodule

//--- pcpu_top.f
src/cpu_pkg.sv
src/pipe_bus.sv
src/fetch_stage.sv
src/decode_stage.sv
src/execute_stage.sv
src/memory_writeback.sv
src/pcpu_top.sv
bench/tb_clock.sv
bench/pcpu_asserts.sv
bench/pcpu_tb.sv

//--- program.hex
// one 32-bit instruction word per line, word address 0 first
// the right-hand note is the assembly of that word
24010005 // addiu r1, r0, 5
24020007 // addiu r2, r0, 7
24000009 // addiu r0, r0, 9
00221821 // addu  r3, r1, r2
AC030000 // sw    r3, 0(r0)
00412023 // subu  r4, r2, r1
AC040004 // sw    r4, 4(r0)
3C051234 // lui   r5, 0x1234
AC050008 // sw    r5, 8(r0)
8C060000 // lw    r6, 0(r0)
00C63821 // addu  r7, r6, r6
AC07000C // sw    r7, 12(r0)
0022402A // slt   r8, r1, r2
00224825 // or    r9, r1, r2
00225024 // and   r10, r1, r2
AC080010 // sw    r8, 16(r0)
AC090014 // sw    r9, 20(r0)
10210001 // beq   r1, r1, +1
240B0BAD // addiu r11, r0, 0xbad
AC0A0018 // sw    r10, 24(r0)
08000016 // j     end
240B0BAD // addiu r11, r0, 0xbad
240C600D // end: addiu r12, r0, 0x600d
AC0C001C // sw    r12, 28(r0)
08000018 // j     self

//--- run_sim.sh
#!/usr/bin/env bash
# build the pcpu testbench with verilator, run it and check the log
set -u
cd "$(dirname "$0")" || exit 1

log_file=sim.log
fail_msg='** FAIL **'

if ! verilator --binary --timing --assert --timescale 1ns/100ps \
	--top-module pcpu_tb -Mdir obj_dir -f pcpu_top.f; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/Vpcpu_tb +verilator+error+limit+100 > "$log_file" 2>&1
sim_status=$?
cat "$log_file"

if grep -qF "$fail_msg" "$log_file"; then
	echo "simulation reported a failure"
	exit 1
fi
if [ "$sim_status" -ne 0 ]; then
	echo "simulator exited with status $sim_status"
	exit 1
fi
echo "simulation finished without failures"
exit 0

//--- src/cpu_pkg.sv
package cpu_pkg;

	//////////////////////////////////////////////////
	// sizes
	//////////////////////////////////////////////////

	localparam int XLEN = 32;
	localparam int REG_ADDR_W = 5;
	localparam int NUM_REGS = 32;
	localparam int ROM_WORDS = 64;
	localparam int RAM_WORDS = 32;
	localparam int ROM_AW = $clog2(ROM_WORDS);
	localparam int RAM_AW = $clog2(RAM_WORDS);
	localparam string PROGRAM_FILE = "program.hex";

	//////////////////////////////////////////////////
	// instruction encodings
	//////////////////////////////////////////////////

	// primary opcode, bits 31:26
	typedef enum logic [5:0] {
		op_special = 6'h00,
		op_j       = 6'h02,
		op_beq     = 6'h04,
		op_addiu   = 6'h09,
		op_lui     = 6'h0f,
		op_lw      = 6'h23,
		op_sw      = 6'h2b
	} opcode_e;

	// function field of special, bits 5:0
	typedef enum logic [5:0] {
		fn_addu = 6'h21,
		fn_subu = 6'h23,
		fn_and  = 6'h24,
		fn_or   = 6'h25,
		fn_slt  = 6'h2a
	} funct_e;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_slt,
		alu_pass_b
	} alu_op_e;

	//////////////////////////////////////////////////
	// stage traffic
	//////////////////////////////////////////////////

	typedef struct packed {
		alu_op_e alu_op;
		logic    b_imm;
		logic    reg_write;
		logic    mem_read;
		logic    mem_write;
	} ex_ctrl_t;

	// result sent back to decode for forwarding
	typedef struct packed {
		logic                  valid;
		logic [REG_ADDR_W-1:0] dest;
		logic [XLEN-1:0]       value;
		logic                  load;
	} fwd_t;

endpackage

//--- src/decode_stage.sv
`timescale 1ns/100ps

module decode_stage import cpu_pkg::*; (
	input logic clk_cpu,
	input logic rst,
	fetch_bus.decode fb,
	issue_bus.decode ib,
	input fwd_t ex_fwd,
	input fwd_t mem_fwd,
	input logic wb_en,
	input logic [REG_ADDR_W-1:0] wb_reg,
	input logic [XLEN-1:0] wb_data
);

	logic [XLEN-1:0] regs [NUM_REGS];
	opcode_e opcode;
	funct_e funct;
	logic [REG_ADDR_W-1:0] rs, rt, rd, dest, dest_q;
	logic [XLEN-1:0] imm_ext, rf_a, rf_b, src_a, src_b;
	logic [XLEN-1:0] br_target, j_target;
	logic [XLEN-1:0] op_a_q, op_b_q, imm_q;
	ex_ctrl_t ctrl, ctrl_q;
	logic uses_rs, uses_rt, is_beq, is_j, load_use;

	// newest producer wins, r0 never forwarded
	function automatic logic [XLEN-1:0] pick_src(input logic [REG_ADDR_W-1:0] src,
			input logic [XLEN-1:0] file_val, input fwd_t ex_f, input fwd_t mem_f);
		logic [XLEN-1:0] val;
		val = file_val;
		if (src != '0 && ex_f.valid && ex_f.dest == src) begin
			val = ex_f.value;
		end else if (src != '0 && mem_f.valid && mem_f.dest == src) begin
			val = mem_f.value;
		end
		return val;
	endfunction

	assign opcode = opcode_e'(fb.instr[31:26]);
	assign funct = funct_e'(fb.instr[5:0]);
	assign rs = fb.instr[25:21];
	assign rt = fb.instr[20:16];
	assign rd = fb.instr[15:11];
	assign imm_ext = {{16{fb.instr[15]}}, fb.instr[15:0]};

	//////////////////////////////////////////////////
	// decoder
	//////////////////////////////////////////////////

	always_comb begin
		ctrl = '0;
		ctrl.alu_op = alu_add;
		dest = rt;
		uses_rs = 1'b0;
		uses_rt = 1'b0;
		is_beq = 1'b0;
		is_j = 1'b0;
		case (opcode)
			op_special: begin
				dest = rd;
				uses_rs = 1'b1;
				uses_rt = 1'b1;
				ctrl.reg_write = 1'b1;
				case (funct)
					fn_addu: ctrl.alu_op = alu_add;
					fn_subu: ctrl.alu_op = alu_sub;
					fn_and:  ctrl.alu_op = alu_and;
					fn_or:   ctrl.alu_op = alu_or;
					fn_slt:  ctrl.alu_op = alu_slt;
					// unknown function, no-op
					default: begin
						ctrl.reg_write = 1'b0;
						uses_rs = 1'b0;
						uses_rt = 1'b0;
					end
				endcase
			end
			op_addiu: begin
				uses_rs = 1'b1;
				ctrl.b_imm = 1'b1;
				ctrl.reg_write = 1'b1;
			end
			op_lui: begin
				ctrl.alu_op = alu_pass_b;
				ctrl.b_imm = 1'b1;
				ctrl.reg_write = 1'b1;
			end
			op_lw: begin
				uses_rs = 1'b1;
				ctrl.b_imm = 1'b1;
				ctrl.reg_write = 1'b1;
				ctrl.mem_read = 1'b1;
			end
			op_sw: begin
				uses_rs = 1'b1;
				uses_rt = 1'b1;
				ctrl.b_imm = 1'b1;
				ctrl.mem_write = 1'b1;
			end
			op_beq: begin
				uses_rs = 1'b1;
				uses_rt = 1'b1;
				is_beq = 1'b1;
			end
			op_j: is_j = 1'b1;
			default: ;
		endcase
		// r0 stays zero
		if (dest == '0) begin
			ctrl.reg_write = 1'b0;
		end
	end

	//////////////////////////////////////////////////
	// register file
	//////////////////////////////////////////////////

	always_ff @(posedge clk_cpu) begin
		if (wb_en && wb_reg != '0) begin
			regs[wb_reg] <= wb_data;
		end
	end

	// same-cycle writeback bypasses the array
	assign rf_a = (rs == '0) ? '0 : (wb_en && wb_reg == rs) ? wb_data : regs[rs];
	assign rf_b = (rt == '0) ? '0 : (wb_en && wb_reg == rt) ? wb_data : regs[rt];
	assign src_a = pick_src(rs, rf_a, ex_fwd, mem_fwd);
	assign src_b = pick_src(rt, rf_b, ex_fwd, mem_fwd);

	//////////////////////////////////////////////////
	// hazard and branch resolution
	//////////////////////////////////////////////////

	// load result not ready until memory stage
	assign load_use = ex_fwd.valid && ex_fwd.load &&
		((uses_rs && rs == ex_fwd.dest) || (uses_rt && rt == ex_fwd.dest));

	assign br_target = fb.pc_plus4 + {imm_ext[XLEN-3:0], 2'b00};
	assign j_target = {fb.pc_plus4[31:28], fb.instr[25:0], 2'b00};

	assign fb.stall = load_use;
	assign fb.redirect = !load_use && (is_j || (is_beq && src_a == src_b));
	assign fb.target = is_j ? j_target : br_target;

	//////////////////////////////////////////////////
	// decode to execute register
	//////////////////////////////////////////////////

	always_ff @(posedge clk_cpu or posedge rst) begin
		if (rst) begin
			ctrl_q <= '0;
			dest_q <= '0;
		end else if (load_use) begin
			// bubble
			ctrl_q <= '0;
			dest_q <= '0;
		end else begin
			ctrl_q <= ctrl;
			dest_q <= dest;
		end
	end

	always_ff @(posedge clk_cpu) begin
		op_a_q <= src_a;
		op_b_q <= src_b;
		imm_q <= imm_ext;
	end

	assign ib.ctrl = ctrl_q;
	assign ib.dest = dest_q;
	assign ib.op_a = op_a_q;
	assign ib.op_b = op_b_q;
	assign ib.imm = imm_q;

endmodule

//--- src/execute_stage.sv
`timescale 1ns/100ps

module execute_stage import cpu_pkg::*; (
	input logic clk_cpu,
	input logic rst,
	issue_bus.execute ib,
	retire_bus.execute rb,
	output fwd_t ex_fwd
);

	logic [XLEN-1:0] alu_b;
	logic [XLEN-1:0] alu_y;
	ex_ctrl_t ctrl_q;
	logic [REG_ADDR_W-1:0] dest_q;
	logic [XLEN-1:0] result_q;
	logic [XLEN-1:0] store_q;

	//////////////////////////////////////////////////
	// alu
	//////////////////////////////////////////////////

	assign alu_b = ib.ctrl.b_imm ? ib.imm : ib.op_b;

	always_comb begin
		case (ib.ctrl.alu_op)
			alu_add:    alu_y = ib.op_a + alu_b;
			alu_sub:    alu_y = ib.op_a - alu_b;
			alu_and:    alu_y = ib.op_a & alu_b;
			alu_or:     alu_y = ib.op_a | alu_b;
			alu_slt:    alu_y = {{(XLEN-1){1'b0}}, $signed(ib.op_a) < $signed(alu_b)};
			// lui puts the immediate in the upper half
			alu_pass_b: alu_y = {alu_b[15:0], 16'h0000};
			default:    alu_y = '0;
		endcase
	end

	// for a load this is only the address, decode stalls on it
	always_comb begin
		ex_fwd.valid = ib.ctrl.reg_write;
		ex_fwd.dest = ib.dest;
		ex_fwd.value = alu_y;
		ex_fwd.load = ib.ctrl.mem_read;
	end

	//////////////////////////////////////////////////
	// execute to memory register
	//////////////////////////////////////////////////

	always_ff @(posedge clk_cpu or posedge rst) begin
		if (rst) begin
			ctrl_q <= '0;
			dest_q <= '0;
		end else begin
			ctrl_q <= ib.ctrl;
			dest_q <= ib.dest;
		end
	end

	always_ff @(posedge clk_cpu) begin
		result_q <= alu_y;
		store_q <= ib.op_b;
	end

	assign rb.ctrl = ctrl_q;
	assign rb.dest = dest_q;
	assign rb.result = result_q;
	assign rb.store_data = store_q;

endmodule

//--- src/fetch_stage.sv
`timescale 1ns/100ps

module fetch_stage import cpu_pkg::*; (
	input logic clk_cpu,
	input logic rst,
	fetch_bus.fetch fb
);

	logic [XLEN-1:0] rom [ROM_WORDS];
	logic [XLEN-1:0] pc;
	logic [XLEN-1:0] pc_plus4;
	logic [XLEN-1:0] rom_word;
	logic [XLEN-1:0] instr_q;
	logic [XLEN-1:0] pc_plus4_q;

	initial begin
		$readmemh(PROGRAM_FILE, rom);
	end

	// word address into the rom
	assign rom_word = rom[pc[ROM_AW+1:2]];
	assign pc_plus4 = pc + 32'd4;

	//////////////////////////////////////////////////
	// pc and fetch register
	//////////////////////////////////////////////////

	// redirect squashes the word fetched behind the branch
	always_ff @(posedge clk_cpu or posedge rst) begin
		if (rst) begin
			pc <= '0;
			instr_q <= '0;
		end else if (fb.redirect) begin
			pc <= fb.target;
			instr_q <= '0;
		end else if (!fb.stall) begin
			pc <= pc_plus4;
			instr_q <= rom_word;
		end
	end

	always_ff @(posedge clk_cpu) begin
		if (!fb.stall) begin
			pc_plus4_q <= pc_plus4;
		end
	end

	assign fb.instr = instr_q;
	assign fb.pc_plus4 = pc_plus4_q;

endmodule

//--- src/memory_writeback.sv
`timescale 1ns/100ps

module memory_writeback import cpu_pkg::*; (
	input logic clk_cpu,
	input logic rst,
	retire_bus.memory rb,
	output fwd_t mem_fwd,
	output logic wb_en,
	output logic [REG_ADDR_W-1:0] wb_reg,
	output logic [XLEN-1:0] wb_data,
	output logic store_en,
	output logic [XLEN-1:0] store_addr,
	output logic [XLEN-1:0] store_data
);

	logic [XLEN-1:0] ram [RAM_WORDS];
	logic [RAM_AW-1:0] ram_idx;
	logic [XLEN-1:0] rd_data;
	logic [XLEN-1:0] sel_data;

	//////////////////////////////////////////////////
	// data ram
	//////////////////////////////////////////////////

	assign ram_idx = rb.result[RAM_AW+1:2];
	assign rd_data = ram[ram_idx];

	assign store_en = rb.ctrl.mem_write;
	assign store_addr = rb.result;
	assign store_data = rb.store_data;

	always_ff @(posedge clk_cpu) begin
		if (store_en) begin
			ram[ram_idx] <= rb.store_data;
		end
	end

	assign sel_data = rb.ctrl.mem_read ? rd_data : rb.result;

	always_comb begin
		mem_fwd.valid = rb.ctrl.reg_write;
		mem_fwd.dest = rb.dest;
		mem_fwd.value = sel_data;
		mem_fwd.load = rb.ctrl.mem_read;
	end

	//////////////////////////////////////////////////
	// writeback register
	//////////////////////////////////////////////////

	always_ff @(posedge clk_cpu or posedge rst) begin
		if (rst) begin
			wb_en <= 1'b0;
			wb_reg <= '0;
		end else begin
			wb_en <= rb.ctrl.reg_write;
			wb_reg <= rb.dest;
		end
	end

	always_ff @(posedge clk_cpu) begin
		wb_data <= sel_data;
	end

endmodule

//--- src/pcpu_top.sv
`timescale 1ns/100ps

module pcpu_top import cpu_pkg::*; (
	input logic clk_cpu,
	input logic rst,
	output logic retire_en,
	output logic [REG_ADDR_W-1:0] retire_reg,
	output logic [XLEN-1:0] retire_data,
	output logic store_en,
	output logic [XLEN-1:0] store_addr,
	output logic [XLEN-1:0] store_data
);

	fetch_bus fb ();
	issue_bus ib ();
	retire_bus rb ();

	fwd_t ex_fwd;
	fwd_t mem_fwd;
	logic wb_en;
	logic [REG_ADDR_W-1:0] wb_reg;
	logic [XLEN-1:0] wb_data;

	//////////////////////////////////////////////////
	// pipeline stages
	//////////////////////////////////////////////////

	fetch_stage u_fetch (
		.clk_cpu (clk_cpu),
		.rst     (rst),
		.fb      (fb)
	);

	decode_stage u_decode (
		.clk_cpu (clk_cpu),
		.rst     (rst),
		.fb      (fb),
		.ib      (ib),
		.ex_fwd  (ex_fwd),
		.mem_fwd (mem_fwd),
		.wb_en   (wb_en),
		.wb_reg  (wb_reg),
		.wb_data (wb_data)
	);

	execute_stage u_execute (
		.clk_cpu (clk_cpu),
		.rst     (rst),
		.ib      (ib),
		.rb      (rb),
		.ex_fwd  (ex_fwd)
	);

	memory_writeback u_memwb (
		.clk_cpu    (clk_cpu),
		.rst        (rst),
		.rb         (rb),
		.mem_fwd    (mem_fwd),
		.wb_en      (wb_en),
		.wb_reg     (wb_reg),
		.wb_data    (wb_data),
		.store_en   (store_en),
		.store_addr (store_addr),
		.store_data (store_data)
	);

	// writeback is also the retire report
	assign retire_en = wb_en;
	assign retire_reg = wb_reg;
	assign retire_data = wb_data;

endmodule

//--- src/pipe_bus.sv
`timescale 1ns/100ps

//////////////////////////////////////////////////
// fetch <-> decode
//////////////////////////////////////////////////

interface fetch_bus import cpu_pkg::*; ();
	logic [XLEN-1:0] instr;
	logic [XLEN-1:0] pc_plus4;
	// back from decode
	logic            stall;
	logic            redirect;
	logic [XLEN-1:0] target;

	modport fetch (
		output instr,
		output pc_plus4,
		input  stall,
		input  redirect,
		input  target
	);

	modport decode (
		input  instr,
		input  pc_plus4,
		output stall,
		output redirect,
		output target
	);
endinterface

//////////////////////////////////////////////////
// decode -> execute
//////////////////////////////////////////////////

interface issue_bus import cpu_pkg::*; ();
	ex_ctrl_t              ctrl;
	logic [XLEN-1:0]       op_a;
	logic [XLEN-1:0]       op_b;
	logic [XLEN-1:0]       imm;
	logic [REG_ADDR_W-1:0] dest;

	modport decode (output ctrl, output op_a, output op_b, output imm, output dest);
	modport execute (input ctrl, input op_a, input op_b, input imm, input dest);
endinterface

//////////////////////////////////////////////////
// execute -> memory
//////////////////////////////////////////////////

interface retire_bus import cpu_pkg::*; ();
	ex_ctrl_t              ctrl;
	logic [XLEN-1:0]       result;
	logic [XLEN-1:0]       store_data;
	logic [REG_ADDR_W-1:0] dest;

	modport execute (output ctrl, output result, output store_data, output dest);
	modport memory (input ctrl, input result, input store_data, input dest);
endinterface
